// File: logic/ecc_mem_pkg.sv
package ecc_mem_pkg;

    localparam int ECC_DATA_WIDTH   = 22;
    localparam int ECC_PARITY_WIDTH = 6;

    // Stored codeword. The same layout carries the fault-injection pattern.
    typedef struct packed {
        logic [ECC_DATA_WIDTH-1:0]   data;
        logic [ECC_PARITY_WIDTH-1:0] parity;
    } ecc_word_t;

    // Read response after correction.
    typedef struct packed {
        logic [ECC_DATA_WIDTH-1:0] data;
        logic                      sbit_err;
        logic                      dbit_err;
    } rd_rsp_t;

    // Check bits of one data word. Every column has odd weight.
    function automatic logic [ECC_PARITY_WIDTH-1:0] ecc_encode(
        input logic [ECC_DATA_WIDTH-1:0] d
    );
        logic [ECC_PARITY_WIDTH-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10]
             ^ d[11] ^ d[13] ^ d[15] ^ d[17] ^ d[19] ^ d[21];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10]
             ^ d[12] ^ d[13] ^ d[16] ^ d[17] ^ d[20] ^ d[21];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10]
             ^ d[14] ^ d[15] ^ d[16] ^ d[17];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10]
             ^ d[18] ^ d[19] ^ d[20] ^ d[21];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[18] ^ d[19] ^ d[20] ^ d[21];
        p[5] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10]
             ^ d[11] ^ d[12] ^ d[14] ^ d[17] ^ d[18] ^ d[21];
        return p;
    endfunction

endpackage

// File: logic/ecc_22_cal.sv
`timescale 1ns/100ps

module ecc_22_cal (
    input  logic [ecc_mem_pkg::ECC_DATA_WIDTH-1:0]   data_in,
    input  logic [ecc_mem_pkg::ECC_PARITY_WIDTH-1:0] parity_in,
    input  logic                                     bypass,
    output logic [ecc_mem_pkg::ECC_DATA_WIDTH-1:0]   data_out,
    output logic [ecc_mem_pkg::ECC_PARITY_WIDTH-1:0] parity_out,
    output logic [ecc_mem_pkg::ECC_DATA_WIDTH-1:0]   mask,
    output logic                                     sbit_err,
    output logic                                     dbit_err
);
    import ecc_mem_pkg::*;

    logic [ECC_PARITY_WIDTH-1:0] syndrome;
    logic                        data_hit;
    logic                        parity_hit;
    logic                        single_err;
    logic                        double_err;

    assign parity_out = ecc_encode(data_in); // Recomputed check bits.
    assign syndrome   = parity_in ^ parity_out;

    // A data bit is in error when the syndrome equals its column of the code.
    always_comb begin
        logic [ECC_DATA_WIDTH-1:0] col_sel;
        mask = '0;
        for (int i = 0; i < ECC_DATA_WIDTH; i++) begin
            col_sel    = '0;
            col_sel[i] = 1'b1;
            if (syndrome == ecc_encode(col_sel)) begin
                mask[i] = 1'b1;
            end
        end
    end

    assign data_hit   = |mask;
    assign parity_hit = $onehot(syndrome); // Check bit flipped, data is intact.
    assign single_err = data_hit | parity_hit;

    // Even weight syndromes never match a column, so they mark two flips.
    assign double_err = (syndrome != '0) && !single_err;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : single_err;
    assign dbit_err = bypass ? 1'b0 : double_err;

endmodule

// File: logic/ecc_write_port.sv
`timescale 1ns/100ps

module ecc_write_port #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wr_en,
    input  logic [ADDR_WIDTH-1:0]                  wr_addr,
    input  logic [ecc_mem_pkg::ECC_DATA_WIDTH-1:0] wr_data,
    input  ecc_mem_pkg::ecc_word_t                 wr_flip,
    output logic                                   word_wr_en,
    output logic [ADDR_WIDTH-1:0]                  word_addr,
    output ecc_mem_pkg::ecc_word_t                 word
);
    import ecc_mem_pkg::*;

    ecc_word_t code_word;

    always_comb begin
        code_word.data   = wr_data;
        code_word.parity = ecc_encode(wr_data);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_wr_en <= 1'b0;
        end else begin
            word_wr_en <= wr_en;
        end
    end

    // Injected faults are folded in before the word reaches the array.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            word_addr <= wr_addr;
            word      <= code_word ^ wr_flip;
        end
    end

endmodule

// File: logic/ecc_mem_array.sv
`timescale 1ns/100ps

module ecc_mem_array #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_wr_en,
    input  logic [ADDR_WIDTH-1:0]  word_addr,
    input  ecc_mem_pkg::ecc_word_t word,
    input  logic                   rd_en,
    input  logic [ADDR_WIDTH-1:0]  rd_addr,
    output logic                   word_valid,
    output logic [ADDR_WIDTH-1:0]  raw_addr,
    output ecc_mem_pkg::ecc_word_t raw_word
);
    import ecc_mem_pkg::*;

    ecc_word_t mem [2**ADDR_WIDTH];

    // Read-first. A same-edge write is seen by the next read.
    always_ff @(posedge clk) begin
        if (word_wr_en) begin
            mem[word_addr] <= word;
        end
        if (rd_en) begin
            raw_word <= mem[rd_addr];
            raw_addr <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= rd_en;
        end
    end

endmodule

// File: logic/ecc_read_port.sv
`timescale 1ns/100ps

module ecc_read_port #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_valid,
    input  logic [ADDR_WIDTH-1:0]  raw_addr,
    input  ecc_mem_pkg::ecc_word_t raw_word,
    input  logic                   ecc_bypass,
    output logic                   rd_valid,
    output ecc_mem_pkg::rd_rsp_t   rd_rsp,
    output logic [ADDR_WIDTH-1:0]  rd_rsp_addr
);
    import ecc_mem_pkg::*;

    logic [ECC_DATA_WIDTH-1:0] cor_data;
    logic                      cor_sbit;
    logic                      cor_dbit;

    // Bypass level is taken in the same cycle as the raw word.
    ecc_22_cal ecc_22_cal_inst (
        .data_in    (raw_word.data),
        .parity_in  (raw_word.parity),
        .bypass     (ecc_bypass),
        .data_out   (cor_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (cor_sbit),
        .dbit_err   (cor_dbit)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= word_valid;
        end
    end

    // Output stage.
    always_ff @(posedge clk) begin
        if (word_valid) begin
            rd_rsp.data     <= cor_data;
            rd_rsp.sbit_err <= cor_sbit;
            rd_rsp.dbit_err <= cor_dbit;
            rd_rsp_addr     <= raw_addr;
        end
    end

endmodule

// File: logic/ecc_err_log.sv
`timescale 1ns/100ps

module ecc_err_log #(
    parameter int ADDR_WIDTH = 6,
    parameter int CNT_WIDTH  = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_valid,
    input  ecc_mem_pkg::rd_rsp_t  rd_rsp,
    input  logic [ADDR_WIDTH-1:0] rd_rsp_addr,
    input  logic                  clr_log,
    output logic [CNT_WIDTH-1:0]  sbit_count,
    output logic [CNT_WIDTH-1:0]  dbit_count,
    output logic [ADDR_WIDTH-1:0] last_err_addr,
    output logic                  err_seen
);

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = rd_valid && rd_rsp.sbit_err;
    assign dbit_hit = rd_valid && rd_rsp.dbit_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
            err_seen      <= 1'b0;
        end else if (clr_log) begin // Clear wins over a same-cycle error.
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
            err_seen      <= 1'b0;
        end else begin
            // Counters hold at all ones.
            if (sbit_hit && (sbit_count != '1)) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_hit && (dbit_count != '1)) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (sbit_hit || dbit_hit) begin
                last_err_addr <= rd_rsp_addr;
                err_seen      <= 1'b1;
            end
        end
    end

endmodule

// File: logic/ecc_mem_top.sv
`timescale 1ns/100ps

module ecc_mem_top #(
    parameter int ADDR_WIDTH = 6,
    parameter int CNT_WIDTH  = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   wr_en,
    input  logic [ADDR_WIDTH-1:0]                  wr_addr,
    input  logic [ecc_mem_pkg::ECC_DATA_WIDTH-1:0] wr_data,
    input  ecc_mem_pkg::ecc_word_t                 wr_flip,
    input  logic                                   rd_en,
    input  logic [ADDR_WIDTH-1:0]                  rd_addr,
    input  logic                                   ecc_bypass,
    input  logic                                   clr_log,
    output logic                                   rd_valid,
    output ecc_mem_pkg::rd_rsp_t                   rd_rsp,
    output logic [ADDR_WIDTH-1:0]                  rd_rsp_addr,
    output logic [CNT_WIDTH-1:0]                   sbit_count,
    output logic [CNT_WIDTH-1:0]                   dbit_count,
    output logic [ADDR_WIDTH-1:0]                  last_err_addr,
    output logic                                   err_seen
);
    import ecc_mem_pkg::*;

    logic                  word_wr_en;
    logic [ADDR_WIDTH-1:0] word_addr;
    ecc_word_t             word;
    logic                  word_valid;
    logic [ADDR_WIDTH-1:0] raw_addr;
    ecc_word_t             raw_word;

    ecc_write_port #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) ecc_write_port_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_flip    (wr_flip),
        .word_wr_en (word_wr_en),
        .word_addr  (word_addr),
        .word       (word)
    );

    ecc_mem_array #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) ecc_mem_array_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_wr_en (word_wr_en),
        .word_addr  (word_addr),
        .word       (word),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .word_valid (word_valid),
        .raw_addr   (raw_addr),
        .raw_word   (raw_word)
    );

    ecc_read_port #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) ecc_read_port_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .word_valid  (word_valid),
        .raw_addr    (raw_addr),
        .raw_word    (raw_word),
        .ecc_bypass  (ecc_bypass),
        .rd_valid    (rd_valid),
        .rd_rsp      (rd_rsp),
        .rd_rsp_addr (rd_rsp_addr)
    );

    ecc_err_log #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) ecc_err_log_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid      (rd_valid),
        .rd_rsp        (rd_rsp),
        .rd_rsp_addr   (rd_rsp_addr),
        .clr_log       (clr_log),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr),
        .err_seen      (err_seen)
    );

endmodule

// File: tests/ecc_mem_tb.sv
`timescale 1ns/100ps

module ecc_mem_tb;
    import ecc_mem_pkg::*;

    localparam int ADDR_WIDTH = 4;
    localparam int CNT_WIDTH  = 4;
    localparam int DEPTH      = 2**ADDR_WIDTH;

    logic                      clk;
    logic                      rst_n;
    logic                      wr_en;
    logic [ADDR_WIDTH-1:0]     wr_addr;
    logic [ECC_DATA_WIDTH-1:0] wr_data;
    ecc_word_t                 wr_flip;
    logic                      rd_en;
    logic [ADDR_WIDTH-1:0]     rd_addr;
    logic                      ecc_bypass;
    logic                      clr_log;
    logic                      rd_valid;
    rd_rsp_t                   rd_rsp;
    logic [ADDR_WIDTH-1:0]     rd_rsp_addr;
    logic [CNT_WIDTH-1:0]      sbit_count;
    logic [CNT_WIDTH-1:0]      dbit_count;
    logic [ADDR_WIDTH-1:0]     last_err_addr;
    logic                      err_seen;

    ecc_mem_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) ecc_mem_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_flip       (wr_flip),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .ecc_bypass    (ecc_bypass),
        .clr_log       (clr_log),
        .rd_valid      (rd_valid),
        .rd_rsp        (rd_rsp),
        .rd_rsp_addr   (rd_rsp_addr),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr),
        .err_seen      (err_seen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    logic [31:0] lfsr = 32'd85991;

    // Operation for the next cycle.
    logic                      op_wr;
    logic [ADDR_WIDTH-1:0]     op_wr_addr;
    logic [ECC_DATA_WIDTH-1:0] op_wr_data;
    ecc_word_t                 op_flip;
    int                        op_flip_cnt;
    logic                      op_rd;
    logic [ADDR_WIDTH-1:0]     op_rd_addr;
    logic                      op_rd_byp;
    logic                      op_clr;

    // Memory model, per address.
    logic [ECC_DATA_WIDTH-1:0] m_data [DEPTH];
    ecc_word_t                 m_flip [DEPTH];
    int                        m_cnt  [DEPTH];

    // Writes in flight toward the array.
    logic                      wv1 = 1'b0, wv2 = 1'b0;
    logic [ADDR_WIDTH-1:0]     wa1, wa2;
    logic [ECC_DATA_WIDTH-1:0] wd1, wd2;
    ecc_word_t                 wf1, wf2;
    int                        wc1, wc2;

    // Reads in flight toward rd_valid.
    logic                      pv1 = 1'b0, pv2 = 1'b0;
    rd_rsp_t                   prsp1, prsp2;
    logic [ADDR_WIDTH-1:0]     paddr1, paddr2;
    logic                      byp_next = 1'b0;

    logic [CNT_WIDTH-1:0]      m_sbit = '0;
    logic [CNT_WIDTH-1:0]      m_dbit = '0;
    logic [ADDR_WIDTH-1:0]     m_last = '0;
    logic                      m_seen = 1'b0;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic compare_rsp(input string name, input rd_rsp_t exp, input rd_rsp_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_addr(input string name, input logic [ADDR_WIDTH-1:0] exp,
                                input logic [ADDR_WIDTH-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_count(input string name, input logic [CNT_WIDTH-1:0] exp,
                                 input logic [CNT_WIDTH-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Response that the code rules give for the word now stored at an address.
    function automatic rd_rsp_t expect_rsp(input logic [ADDR_WIDTH-1:0] a, input logic byp);
        rd_rsp_t r;
        logic [ECC_DATA_WIDTH-1:0] stored;
        stored = m_data[a] ^ m_flip[a].data;
        if (byp)               r = '{data: stored,    sbit_err: 1'b0, dbit_err: 1'b0};
        else if (m_cnt[a] == 0) r = '{data: m_data[a], sbit_err: 1'b0, dbit_err: 1'b0};
        else if (m_cnt[a] == 1) r = '{data: m_data[a], sbit_err: 1'b1, dbit_err: 1'b0};
        else                    r = '{data: stored,    sbit_err: 1'b0, dbit_err: 1'b1};
        return r;
    endfunction

    task automatic idle_ops();
        op_wr       = 1'b0;
        op_wr_addr  = '0;
        op_wr_data  = '0;
        op_flip     = '0;
        op_flip_cnt = 0;
        op_rd       = 1'b0;
        op_rd_addr  = '0;
        op_rd_byp   = 1'b0;
        op_clr      = 1'b0;
    endtask

    // Flip pattern of 0, 1 or 2 distinct bits anywhere in the 28-bit codeword.
    task automatic random_flip();
        logic [31:0] r;
        logic [31:0] pos1;
        logic [31:0] pos2;
        rand_bits(2, r);
        op_flip_cnt = (r == 3) ? 1 : int'(r);
        op_flip     = '0;
        rand_bits(5, pos1);
        pos1 = pos1 % 28;
        rand_bits(5, pos2);
        pos2 = (pos1 + 1 + (pos2 % 27)) % 28;
        if (op_flip_cnt >= 1) op_flip[pos1] = 1'b1;
        if (op_flip_cnt == 2) op_flip[pos2] = 1'b1;
    endtask

    // One clock cycle. Outputs are checked at the falling edge, then new inputs are driven.
    task automatic cycle();
        rd_rsp_t exp_rsp;
        @(negedge clk);
        compare_count("sbit_count", m_sbit, sbit_count);
        compare_count("dbit_count", m_dbit, dbit_count);
        compare_addr("last_err_addr", m_last, last_err_addr);
        compare_flag("err_seen", m_seen, err_seen);
        compare_flag("rd_valid", pv2, rd_valid); // Exactly two cycles after the read.
        if (pv2) begin
            compare_rsp("rd_rsp", prsp2, rd_rsp);
            compare_addr("rd_rsp_addr", paddr2, rd_rsp_addr);
        end
        if (op_clr) begin
            m_sbit = '0;
            m_dbit = '0;
            m_last = '0;
            m_seen = 1'b0;
        end else if (pv2 && (prsp2.sbit_err || prsp2.dbit_err)) begin
            if (prsp2.sbit_err && m_sbit != 15) m_sbit = m_sbit + 1'b1;
            if (prsp2.dbit_err && m_dbit != 15) m_dbit = m_dbit + 1'b1;
            m_last = paddr2;
            m_seen = 1'b1;
        end
        if (wv2) begin // Landed one edge ago, visible to this read.
            m_data[wa2] = wd2;
            m_flip[wa2] = wf2;
            m_cnt[wa2]  = wc2;
        end
        wv2 = wv1;
        wa2 = wa1;
        wd2 = wd1;
        wf2 = wf1;
        wc2 = wc1;
        wv1 = op_wr;
        wa1 = op_wr_addr;
        wd1 = op_wr_data;
        wf1 = op_flip;
        wc1 = op_flip_cnt;
        exp_rsp = op_rd ? expect_rsp(op_rd_addr, op_rd_byp) : '0;
        pv2    = pv1;
        prsp2  = prsp1;
        paddr2 = paddr1;
        pv1    = op_rd;
        prsp1  = exp_rsp;
        paddr1 = op_rd_addr;
        ecc_bypass = byp_next; // Goes with the raw word of last cycle's read.
        byp_next   = op_rd ? op_rd_byp : 1'b0;
        wr_en      = op_wr;
        wr_addr    = op_wr_addr;
        wr_data    = op_wr_data;
        wr_flip    = op_flip;
        rd_en      = op_rd;
        rd_addr    = op_rd_addr;
        clr_log    = op_clr;
    endtask

    initial begin
        logic [31:0] r;
        int          guard;
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        wr_flip    = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        ecc_bypass = 1'b0;
        clr_log    = 1'b0;
        idle_ops();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Clean contents everywhere, since the array has no reset.
        for (int a = 0; a < DEPTH; a++) begin
            idle_ops();
            op_wr      = 1'b1;
            op_wr_addr = a;
            rand_bits(ECC_DATA_WIDTH, r);
            op_wr_data = r[ECC_DATA_WIDTH-1:0];
            cycle();
        end
        idle_ops();
        repeat (2) cycle();

        // Read one cycle after a write to the same address gets the old word.
        op_wr       = 1'b1;
        op_wr_addr  = 4'd5;
        op_wr_data  = 22'h2A_5A5A;
        op_flip[9]  = 1'b1;
        op_flip_cnt = 1;
        cycle();
        idle_ops();
        op_rd      = 1'b1;
        op_rd_addr = 4'd5;
        cycle();
        cycle();
        idle_ops();

        for (int n = 0; n < 400; n++) begin
            idle_ops();
            rand_bits(1, r);
            op_wr = r[0];
            rand_bits(ADDR_WIDTH, r);
            op_wr_addr = r[ADDR_WIDTH-1:0];
            rand_bits(ECC_DATA_WIDTH, r);
            op_wr_data = r[ECC_DATA_WIDTH-1:0];
            if (op_wr) random_flip();
            rand_bits(2, r);
            op_rd = (r != 0);
            rand_bits(ADDR_WIDTH, r);
            op_rd_addr = r[ADDR_WIDTH-1:0];
            rand_bits(2, r);
            op_rd_byp = (r == 0);
            rand_bits(5, r);
            op_clr = (r == 0);
            cycle();
        end

        // A double-error word and a single-error word, read until both counters saturate.
        idle_ops();
        op_wr       = 1'b1;
        op_wr_addr  = 4'd2;
        op_wr_data  = 22'h15_A5A5;
        op_flip[0]  = 1'b1;
        op_flip[20] = 1'b1;
        op_flip_cnt = 2;
        cycle();
        idle_ops();
        op_wr       = 1'b1;
        op_wr_addr  = 4'd3;
        op_wr_data  = 22'h0A_5A5A;
        op_flip[27] = 1'b1;
        op_flip_cnt = 1;
        cycle();
        idle_ops();
        repeat (2) cycle();
        for (int n = 0; n < 40; n++) begin
            idle_ops();
            op_rd      = 1'b1;
            op_rd_addr = n[0] ? 4'd3 : 4'd2;
            cycle();
        end

        idle_ops();
        guard = 0;
        while (pv1 || pv2 || rd_valid) begin
            cycle();
            guard++;
            if (guard > 10) fail_run("Timeout: read pipeline did not drain.");
        end
        repeat (2) cycle();

        op_clr = 1'b1;
        cycle();
        idle_ops();
        repeat (2) cycle();
        compare_count("sbit_count after clear", '0, sbit_count);
        compare_count("dbit_count after clear", '0, dbit_count);
        compare_addr("last_err_addr after clear", '0, last_err_addr);
        compare_flag("err_seen after clear", 1'b0, err_seen);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: ecc_mem_top.f
logic/ecc_mem_pkg.sv
logic/ecc_22_cal.sv
logic/ecc_write_port.sv
logic/ecc_mem_array.sv
logic/ecc_read_port.sv
logic/ecc_err_log.sv
logic/ecc_mem_top.sv
tests/ecc_mem_tb.sv

// File: Bender.yml
package:
  name: ecc_mem

sources:
  - logic/ecc_mem_pkg.sv
  - logic/ecc_22_cal.sv
  - logic/ecc_write_port.sv
  - logic/ecc_mem_array.sv
  - logic/ecc_read_port.sv
  - logic/ecc_err_log.sv
  - logic/ecc_mem_top.sv
  - target: test
    files:
      - tests/ecc_mem_tb.sv
